// ==== design/rv32i_pkg.sv ====
// ================================================
// Shared RV32I encodings and instruction formats
// Imported by the core RTL for opcodes, funct3 codes,
// ALU operations, datapath selects and the halt word
// ================================================

package rv32i_pkg;

  // Major opcodes
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    IMMED  = 7'b0010011,
    REGREG = 7'b0110011,
    SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_AND  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  typedef enum logic [2:0] {
    ADDI = 3'd0, SLLI = 3'd1, SLTI = 3'd2, SLTIU = 3'd3,
    XORI = 3'd4, SRI  = 3'd5, ORI  = 3'd6, ANDI  = 3'd7
  } funct3_imm_t;

  typedef enum logic [2:0] {
    ADDSUB = 3'd0, SLL = 3'd1, SLT = 3'd2, SLTU = 3'd3,
    XOR    = 3'd4, SR  = 3'd5, OR  = 3'd6, AND  = 3'd7
  } funct3_reg_t;

  typedef enum logic [2:0] {
    BEQ = 3'd0, BNE = 3'd1, BLT = 3'd4, BGE = 3'd5, BLTU = 3'd6, BGEU = 3'd7
  } branch_t;

  typedef enum logic [2:0] {
    LB = 3'd0, LH = 3'd1, LW = 3'd2, LBU = 3'd4, LHU = 3'd5
  } load_t;

  // One struct per instruction format, MSB first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } rtype_t;

  typedef struct packed {
    logic [11:0] imm11_00;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0] imm11_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm04_00;
    opcode_t    opcode;
  } stype_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm04_01;
    logic       imm11;
    opcode_t    opcode;
  } sbtype_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
  } utype_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_01;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } ujtype_t;

  typedef union packed {
    rtype_t  r;
    itype_t  i;
    stype_t  s;
    sbtype_t sb;
    utype_t  u;
    ujtype_t uj;
  } rv32i_instr_u;

  typedef enum logic [1:0] {A_RS1 = 2'd0, A_PC = 2'd1} alu_a_sel_t;

  typedef enum logic [1:0] {B_RS2 = 2'd0, B_IMM = 2'd1} alu_b_sel_t;

  typedef enum logic [2:0] {
    WB_LOAD = 3'd0, WB_PC_PLUS4 = 3'd1, WB_IMM_U = 3'd2, WB_ALU = 3'd3
  } wb_sel_t;

  // SYSTEM word used as the halt request
  localparam logic [31:0] HALT_INSN = 32'h7800d073;

endpackage

// ==== design/control_unit.sv ====
// ================================================
// Combinational RV32I decoder
// Turns the fetched word into register indices, the
// immediate, ALU and writeback selects and enables
// ================================================
`timescale 1ns/1ns

module control_unit import rv32i_pkg::*; (
  input  logic [31:0] instr_i,
  input  logic        halted_i,
  output logic [4:0]  rs1_o,
  output logic [4:0]  rs2_o,
  output logic [4:0]  rd_o,
  output logic [31:0] imm_o,
  output alu_op_t     alu_op_o,
  output alu_a_sel_t  alu_a_sel_o,
  output alu_b_sel_t  alu_b_sel_o,
  output wb_sel_t     wb_sel_o,
  output logic        reg_wen_o,
  output logic        dmem_wen_o,
  output logic        dmem_ren_o,
  output load_t       load_type_o,
  output logic        branch_o,
  output branch_t     branch_type_o,
  output logic        jump_o,
  output logic        jalr_o,
  output logic        halt_o,
  output logic        illegal_o
);

  rv32i_instr_u instr;
  opcode_t      opcode;
  logic         reg_wen_raw;
  logic         no_commit;

  assign instr  = rv32i_instr_u'(instr_i);
  assign opcode = instr.r.opcode;

  assign rs1_o = instr.r.rs1;
  assign rs2_o = instr.r.rs2;
  assign rd_o  = instr.r.rd;

  // Immediate by format
  always_comb begin
    case (opcode)
      IMMED: begin
        if (instr.i.funct3 == SLLI || instr.i.funct3 == SRI)
          imm_o = {27'b0, instr.r.rs2};
        else
          imm_o = {{20{instr.i.imm11_00[11]}}, instr.i.imm11_00};
      end
      LOAD, JALR: imm_o = {{20{instr.i.imm11_00[11]}}, instr.i.imm11_00};
      STORE:      imm_o = {{20{instr.s.imm11_05[6]}}, instr.s.imm11_05, instr.s.imm04_00};
      BRANCH:     imm_o = {{19{instr.sb.imm12}}, instr.sb.imm12, instr.sb.imm11,
                           instr.sb.imm10_05, instr.sb.imm04_01, 1'b0};
      LUI, AUIPC: imm_o = {instr.u.imm31_12, 12'b0};
      JAL:        imm_o = {{11{instr.uj.imm20}}, instr.uj.imm20, instr.uj.imm19_12,
                           instr.uj.imm11, instr.uj.imm10_01, 1'b0};
      default:    imm_o = 32'b0;
    endcase
  end

  // ALU operation; bit 30 picks SUB and SRA
  always_comb begin
    alu_op_o = ALU_ADD;
    if (opcode == IMMED) begin
      case (funct3_imm_t'(instr.i.funct3))
        SLLI:    alu_op_o = ALU_SLL;
        SLTI:    alu_op_o = ALU_SLT;
        SLTIU:   alu_op_o = ALU_SLTU;
        XORI:    alu_op_o = ALU_XOR;
        SRI:     alu_op_o = instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
        ORI:     alu_op_o = ALU_OR;
        ANDI:    alu_op_o = ALU_AND;
        default: alu_op_o = ALU_ADD;
      endcase
    end else if (opcode == REGREG) begin
      case (funct3_reg_t'(instr.r.funct3))
        ADDSUB:  alu_op_o = instr.r.funct7[5] ? ALU_SUB : ALU_ADD;
        SLL:     alu_op_o = ALU_SLL;
        SLT:     alu_op_o = ALU_SLT;
        SLTU:    alu_op_o = ALU_SLTU;
        XOR:     alu_op_o = ALU_XOR;
        SR:      alu_op_o = instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
        OR:      alu_op_o = ALU_OR;
        default: alu_op_o = ALU_AND;
      endcase
    end
  end

  assign alu_a_sel_o = (opcode == AUIPC) ? A_PC : A_RS1;
  assign alu_b_sel_o = (opcode == REGREG) ? B_RS2 : B_IMM;

  always_comb begin
    case (opcode)
      LOAD:      wb_sel_o = WB_LOAD;
      JAL, JALR: wb_sel_o = WB_PC_PLUS4;
      LUI:       wb_sel_o = WB_IMM_U;
      default:   wb_sel_o = WB_ALU;
    endcase
  end

  always_comb begin
    case (opcode)
      LUI, AUIPC, JAL, JALR, LOAD, IMMED, REGREG: reg_wen_raw = 1'b1;
      default:                                    reg_wen_raw = 1'b0;
    endcase
  end

  // Anything outside the opcode list except the all-zero word
  always_comb begin
    case (opcode)
      LUI, AUIPC, JAL, JALR, BRANCH, LOAD,
      STORE, IMMED, REGREG, SYSTEM,
      opcode_t'(7'b0):  illegal_o = 1'b0;
      default:          illegal_o = 1'b1;
    endcase
  end

  assign halt_o    = (instr_i == HALT_INSN);
  assign no_commit = halted_i | halt_o | illegal_o;

  assign reg_wen_o  = reg_wen_raw & ~no_commit;
  assign dmem_wen_o = (opcode == STORE) & ~no_commit;
  assign dmem_ren_o = (opcode == LOAD);

  assign load_type_o   = load_t'(instr.i.funct3);
  assign branch_type_o = branch_t'(instr.sb.funct3);
  assign branch_o      = (opcode == BRANCH);
  assign jump_o        = (opcode == JAL);
  assign jalr_o        = (opcode == JALR);

endmodule

// ==== design/reg_file.sv ====
// ================================================
// 32 x 32 integer register file
// Two combinational reads, one write at the clock edge
// ================================================
`timescale 1ns/1ns

module reg_file (
  input  logic        CLK,
  input  logic        arst_n_i,
  input  logic [4:0]  rs1_i,
  input  logic [4:0]  rs2_i,
  input  logic [4:0]  rd_i,
  input  logic        wen_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rs1_data_o,
  output logic [31:0] rs2_data_o
);

  // x0 has no storage
  logic [31:0] regs [1:31];

  always_ff @(posedge CLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= 32'b0;
    end else if (wen_i && rd_i != 5'd0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rs1_data_o = (rs1_i == 5'd0) ? 32'b0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == 5'd0) ? 32'b0 : regs[rs2_i];

endmodule

// ==== design/alu.sv ====
// ================================================
// 32-bit integer ALU
// Picks its operands from registers, PC or immediate
// ================================================
`timescale 1ns/1ns

module alu import rv32i_pkg::*; (
  input  alu_op_t     alu_op_i,
  input  alu_a_sel_t  alu_a_sel_i,
  input  alu_b_sel_t  alu_b_sel_i,
  input  logic [31:0] rs1_data_i,
  input  logic [31:0] rs2_data_i,
  input  logic [31:0] pc_i,
  input  logic [31:0] imm_i,
  output logic [31:0] result_o
);

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [4:0]  shamt;

  assign op_a  = (alu_a_sel_i == A_PC) ? pc_i : rs1_data_i;
  assign op_b  = (alu_b_sel_i == B_IMM) ? imm_i : rs2_data_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op_i)
      ALU_SUB:  result_o = op_a - op_b;
      ALU_SLL:  result_o = op_a << shamt;
      ALU_SRL:  result_o = op_a >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(op_a) >>> shamt);
      ALU_AND:  result_o = op_a & op_b;
      ALU_OR:   result_o = op_a | op_b;
      ALU_XOR:  result_o = op_a ^ op_b;
      ALU_SLT:  result_o = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: result_o = {31'b0, op_a < op_b};
      default:  result_o = op_a + op_b;
    endcase
  end

endmodule

// ==== design/pc_logic.sv ====
// ================================================
// Program counter, branch resolution and halt latch
// Chooses the next PC once per clock edge
// ================================================
`timescale 1ns/1ns

module pc_logic import rv32i_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic        CLK,
  input  logic        arst_n_i,
  input  logic        halt_i,
  input  logic        branch_i,
  input  branch_t     branch_type_i,
  input  logic        jump_i,
  input  logic        jalr_i,
  input  logic [31:0] rs1_data_i,
  input  logic [31:0] rs2_data_i,
  input  logic [31:0] imm_i,
  input  logic [31:0] alu_result_i,
  output logic [31:0] pc_o,
  output logic [31:0] pc_plus4_o,
  output logic        halted_o
);

  logic [31:0] pc_q;
  logic [31:0] pc_next;
  logic        halted_q;
  logic        taken;

  always_comb begin
    case (branch_type_i)
      BEQ:     taken = (rs1_data_i == rs2_data_i);
      BNE:     taken = (rs1_data_i != rs2_data_i);
      BLT:     taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
      BGE:     taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      BLTU:    taken = (rs1_data_i < rs2_data_i);
      BGEU:    taken = (rs1_data_i >= rs2_data_i);
      default: taken = 1'b0;
    endcase
  end

  assign pc_plus4_o = pc_q + 32'd4;

  // PC freezes on the halt word and stays frozen
  always_comb begin
    if (halted_q || halt_i)
      pc_next = pc_q;
    else if (jalr_i)
      pc_next = {alu_result_i[31:1], 1'b0};
    else if (jump_i || (branch_i && taken))
      pc_next = pc_q + imm_i;
    else
      pc_next = pc_plus4_o;
  end

  always_ff @(posedge CLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q     <= RESET_PC;
      halted_q <= 1'b0;
    end else begin
      pc_q     <= pc_next;
      halted_q <= halted_q | halt_i;
    end
  end

  assign pc_o     = pc_q;
  assign halted_o = halted_q;

endmodule

// ==== design/writeback_mux.sv ====
// ================================================
// Load alignment and register writeback select
// Extends loaded bytes and halfwords, then picks the result
// ================================================
`timescale 1ns/1ns

module writeback_mux import rv32i_pkg::*; (
  input  wb_sel_t     wb_sel_i,
  input  load_t       load_type_i,
  input  logic [1:0]  addr_lsb_i,
  input  logic [31:0] dmem_rdata_i,
  input  logic [31:0] alu_result_i,
  input  logic [31:0] imm_i,
  input  logic [31:0] pc_plus4_i,
  output logic [31:0] wdata_o
);

  logic [31:0] shifted;
  logic [31:0] load_data;

  // Byte lane moved down to bit 0
  assign shifted = dmem_rdata_i >> {addr_lsb_i, 3'b000};

  always_comb begin
    case (load_type_i)
      LB:      load_data = {{24{shifted[7]}}, shifted[7:0]};
      LH:      load_data = {{16{shifted[15]}}, shifted[15:0]};
      LBU:     load_data = {24'b0, shifted[7:0]};
      LHU:     load_data = {16'b0, shifted[15:0]};
      default: load_data = dmem_rdata_i;
    endcase
  end

  always_comb begin
    case (wb_sel_i)
      WB_LOAD:     wdata_o = load_data;
      WB_PC_PLUS4: wdata_o = pc_plus4_i;
      WB_IMM_U:    wdata_o = imm_i;
      default:     wdata_o = alu_result_i;
    endcase
  end

endmodule

// ==== design/rv32i_core.sv ====
// ================================================
// Single-cycle RV32I core top level
// One instruction per clock; data memory answers in-cycle
// ================================================
`timescale 1ns/1ns

module rv32i_core import rv32i_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic        CLK,
  input  logic        arst_n_i,
  input  logic [31:0] instr_i,
  output logic [31:0] imem_addr_o,
  output logic [31:0] dmem_addr_o,
  output logic [31:0] dmem_wdata_o,
  output logic        dmem_wen_o,
  output logic        dmem_ren_o,
  input  logic [31:0] dmem_rdata_i,
  output logic        halt_o,
  output logic        illegal_o
);

  logic [4:0]  rs1, rs2, rd;
  logic [31:0] imm, rs1_data, rs2_data, alu_result, pc_plus4, wdata;
  logic        reg_wen, branch, jump, jalr, halted;
  alu_op_t     alu_op;
  alu_a_sel_t  alu_a_sel;
  alu_b_sel_t  alu_b_sel;
  wb_sel_t     wb_sel;
  load_t       load_type;
  branch_t     branch_type;

  control_unit u_ctrl (
    .instr_i(instr_i), .halted_i(halted),
    .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm),
    .alu_op_o(alu_op), .alu_a_sel_o(alu_a_sel), .alu_b_sel_o(alu_b_sel),
    .wb_sel_o(wb_sel), .reg_wen_o(reg_wen),
    .dmem_wen_o(dmem_wen_o), .dmem_ren_o(dmem_ren_o), .load_type_o(load_type),
    .branch_o(branch), .branch_type_o(branch_type), .jump_o(jump), .jalr_o(jalr),
    .halt_o(halt_o), .illegal_o(illegal_o)
  );

  reg_file u_rf (
    .CLK(CLK), .arst_n_i(arst_n_i),
    .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd), .wen_i(reg_wen), .wdata_i(wdata),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  alu u_alu (
    .alu_op_i(alu_op), .alu_a_sel_i(alu_a_sel), .alu_b_sel_i(alu_b_sel),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .pc_i(imem_addr_o), .imm_i(imm),
    .result_o(alu_result)
  );

  pc_logic #(.RESET_PC(RESET_PC)) u_pc (
    .CLK(CLK), .arst_n_i(arst_n_i), .halt_i(halt_o),
    .branch_i(branch), .branch_type_i(branch_type), .jump_i(jump), .jalr_i(jalr),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .imm_i(imm),
    .alu_result_i(alu_result),
    .pc_o(imem_addr_o), .pc_plus4_o(pc_plus4), .halted_o(halted)
  );

  writeback_mux u_wb (
    .wb_sel_i(wb_sel), .load_type_i(load_type), .addr_lsb_i(alu_result[1:0]),
    .dmem_rdata_i(dmem_rdata_i), .alu_result_i(alu_result), .imm_i(imm),
    .pc_plus4_i(pc_plus4), .wdata_o(wdata)
  );

  // Data port driven straight from the datapath
  assign dmem_addr_o  = alu_result;
  assign dmem_wdata_o = rs2_data;

endmodule

// ==== sim/rv32i_core_sva.sv ====
// ================================================
// Assertions bound into the RV32I core top level
// Checks x0, the reset PC, memory enables and halt
// ================================================
`timescale 1ns/1ns

module rv32i_core_sva #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input logic        CLK,
  input logic        arst_n_i,
  input logic [31:0] pc_i,
  input logic        dmem_wen_i,
  input logic        dmem_ren_i,
  input logic        halted_i,
  input logic [4:0]  rs1_i,
  input logic [4:0]  rs2_i,
  input logic [31:0] rs1_data_i,
  input logic [31:0] rs2_data_i
);

  x0_rs1: assert property (@(posedge CLK) (rs1_i == 5'd0) |-> (rs1_data_i == 32'h0))
    else $error("x0 read on rs1 is not zero");

  x0_rs2: assert property (@(posedge CLK) (rs2_i == 5'd0) |-> (rs2_data_i == 32'h0))
    else $error("x0 read on rs2 is not zero");

  reset_pc: assert property (@(posedge CLK) !arst_n_i |-> (pc_i == RESET_PC))
    else $error("PC differs from the reset address during reset");

  mem_excl: assert property (@(posedge CLK) disable iff (!arst_n_i)
                             !(dmem_wen_i && dmem_ren_i))
    else $error("Memory read and write enabled together");

  // Halted core must not move its PC
  halt_freeze: assert property (@(posedge CLK) disable iff (!arst_n_i)
                                halted_i |=> $stable(pc_i))
    else $error("PC changed while halted");

endmodule

bind rv32i_core rv32i_core_sva #(.RESET_PC(RESET_PC)) u_sva (
  .CLK        (CLK),
  .arst_n_i   (arst_n_i),
  .pc_i       (imem_addr_o),
  .dmem_wen_i (dmem_wen_o),
  .dmem_ren_i (dmem_ren_o),
  .halted_i   (halted),
  .rs1_i      (rs1),
  .rs2_i      (rs2),
  .rs1_data_i (rs1_data),
  .rs2_data_i (rs2_data)
);

// ==== sim/rv32i_core_tb.sv ====
// ================================================
// Testbench for the single-cycle RV32I core
// Builds an instruction table with a reference model,
// then runs it row by row and checks PC, stores and flags
// ================================================
`timescale 1ns/1ns

module rv32i_core_tb;

  localparam logic [31:0] RESET_ADDR = 32'h0;
  localparam logic [31:0] HALT_WORD  = 32'h7800d073;
  localparam logic [6:0]  OPC_LUI    = 7'b0110111;
  localparam logic [6:0]  OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0]  OPC_JALR   = 7'b1100111;
  localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
  localparam logic [6:0]  OPC_IMM    = 7'b0010011;
  localparam int          MAX_ROWS   = 128;

  logic        CLK;
  logic        arst_n;
  logic [31:0] instr;
  logic [31:0] imem_addr;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_wen;
  logic        dmem_ren;
  logic [31:0] dmem_rdata;
  logic        halt;
  logic        illegal;

  // Stimulus table and expected responses
  logic [31:0] tab_insn [0:MAX_ROWS-1];
  logic [31:0] tab_npc  [0:MAX_ROWS-1];
  logic [31:0] tab_wval [0:MAX_ROWS-1];
  logic [31:0] tab_addr [0:MAX_ROWS-1];
  logic        tab_wen  [0:MAX_ROWS-1];
  logic        tab_ren  [0:MAX_ROWS-1];
  logic        tab_halt [0:MAX_ROWS-1];
  logic        tab_ill  [0:MAX_ROWS-1];
  int          n_rows;

  // Shadow architectural state of the reference model
  logic [31:0] sreg [0:31];
  logic [31:0] smem [0:63];
  logic [31:0] spc;
  logic        shalted;
  logic [31:0] seed;
  logic [31:0] mem [0:63];
  int          pc_errs;
  int          mem_errs;
  int          flag_errs;

  rv32i_core #(.RESET_PC(RESET_ADDR)) DUT (
    .CLK          (CLK),
    .arst_n_i     (arst_n),
    .instr_i      (instr),
    .imem_addr_o  (imem_addr),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_wen_o   (dmem_wen),
    .dmem_ren_o   (dmem_ren),
    .dmem_rdata_i (dmem_rdata),
    .halt_o       (halt),
    .illegal_o    (illegal)
  );

  // Data memory answers in the same cycle
  assign dmem_rdata = dmem_ren ? mem[dmem_addr[7:2]] : 32'h0;

  always @(posedge CLK) begin
    if (dmem_wen)
      mem[dmem_addr[7:2]] = dmem_wdata;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] mem_pattern(input logic [5:0] idx);
    return (32'h9e3779b9 * ({26'h0, idx} + 32'd1)) ^ {idx, idx, idx, idx, 8'h5a};
  endfunction

  function automatic logic [31:0] rtype_word(input logic alt, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // SW rs2, 0(x10)
  function automatic logic [31:0] store_to_base(input logic [4:0] rs2);
    return {7'b0, rs2, 5'd10, 3'b010, 5'b0, 7'b0100011};
  endfunction

  function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] utype_word(input logic [19:0] upper, input logic [4:0] rd,
                                             input logic [6:0] opc);
    return {upper, rd, opc};
  endfunction

  function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // RV32I integer operation by funct3, alt selects SUB and SRA
  function automatic logic [31:0] expected_alu(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'd3:    return (x < y) ? 32'd1 : 32'd0;
      3'd4:    return x ^ y;
      3'd5:    return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  // Executes one word on the shadow state and appends its row
  task automatic add_row(input logic [31:0] insn);
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] res;
    logic [31:0] npc;
    logic        wr_rd;
    logic        taken;
    logic        ill;
    logic        hlt;
    logic        wen;
    logic        ren;
    begin
      f3    = insn[14:12];
      rd    = insn[11:7];
      a     = sreg[insn[19:15]];
      b     = sreg[insn[24:20]];
      imm_i = {{20{insn[31]}}, insn[31:20]};
      addr  = 32'h0;
      res   = 32'h0;
      npc   = spc + 32'd4;
      wr_rd = 1'b0;
      wen   = 1'b0;
      ren   = 1'b0;
      ill   = 1'b0;
      taken = 1'b0;
      hlt   = (insn == HALT_WORD);
      case (insn[6:0])
        7'b0110111: begin
          res   = {insn[31:12], 12'h0};
          wr_rd = 1'b1;
        end
        7'b0010111: begin
          res   = spc + {insn[31:12], 12'h0};
          wr_rd = 1'b1;
        end
        7'b1101111: begin
          res   = spc + 32'd4;
          wr_rd = 1'b1;
          npc   = spc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
        end
        7'b1100111: begin
          res   = spc + 32'd4;
          wr_rd = 1'b1;
          npc   = (a + imm_i) & ~32'h1;
        end
        7'b1100011: begin
          case (f3)
            3'd0:    taken = (a == b);
            3'd1:    taken = (a != b);
            3'd4:    taken = ($signed(a) < $signed(b));
            3'd5:    taken = ($signed(a) >= $signed(b));
            3'd6:    taken = (a < b);
            3'd7:    taken = (a >= b);
            default: taken = 1'b0;
          endcase
          if (taken)
            npc = spc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
        end
        7'b0000011: begin
          addr  = a + imm_i;
          word  = smem[addr[7:2]] >> (8 * addr[1:0]);
          wr_rd = 1'b1;
          ren   = 1'b1;
          case (f3)
            3'd0:    res = {{24{word[7]}}, word[7:0]};
            3'd1:    res = {{16{word[15]}}, word[15:0]};
            3'd4:    res = {24'h0, word[7:0]};
            3'd5:    res = {16'h0, word[15:0]};
            default: res = word;
          endcase
        end
        7'b0100011: begin
          addr = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
          wen  = 1'b1;
        end
        7'b0010011: begin
          res   = expected_alu(f3, (f3 == 3'd5) & insn[30], a, imm_i);
          wr_rd = 1'b1;
        end
        7'b0110011: begin
          res   = expected_alu(f3, insn[30], a, b);
          wr_rd = 1'b1;
        end
        7'b1110011, 7'b0000000: res = 32'h0;
        default: ill = 1'b1;
      endcase
      // Halt freezes the PC and blocks every write
      if (shalted || hlt) begin
        npc   = spc;
        wr_rd = 1'b0;
        wen   = 1'b0;
      end
      if (wr_rd && rd != 5'd0)
        sreg[rd] = res;
      if (wen)
        smem[addr[7:2]] = b;
      tab_insn[n_rows] = insn;
      tab_npc[n_rows]  = npc;
      tab_wen[n_rows]  = wen;
      tab_ren[n_rows]  = ren;
      tab_addr[n_rows] = addr;
      tab_wval[n_rows] = b;
      tab_halt[n_rows] = hlt;
      tab_ill[n_rows]  = ill;
      n_rows  = n_rows + 1;
      spc     = npc;
      shalted = shalted | hlt;
    end
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
    logic [31:0] upper;
    begin
      upper = val + 32'h800;
      add_row(utype_word(upper[31:12], rd, OPC_LUI));
      add_row(itype_word(val[11:0], rd, 3'd0, rd, OPC_IMM));
    end
  endtask

  task automatic build_program();
    logic [11:0] imm;
    logic [2:0]  f3;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [5:0]  w;
    logic [1:0]  off;
    begin
      seed = 32'd89257;
      for (int r = 1; r <= 4; r++) begin
        seed = lcg_next(seed);
        load_const(5'(r), seed);
      end
      // Fixed pair where signed and unsigned order differ
      load_const(5'd7, 32'hffff_fffb);
      load_const(5'd8, 32'd3);
      add_row(itype_word(12'd64, 5'd0, 3'd0, 5'd10, OPC_IMM));
      for (int k = 0; k < 10; k++) begin
        f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
        rs1 = (k % 2 == 0) ? 5'd1 : 5'd3;
        add_row(rtype_word(k >= 8, rs1 + 5'd1, rs1, f3, 5'd5));
        add_row(store_to_base(5'd5));
      end
      // Shifts carry the shift amount in the low immediate bits
      for (int k = 0; k < 9; k++) begin
        f3   = (k < 8) ? 3'(k) : 3'd5;
        seed = lcg_next(seed);
        imm  = seed[23:12];
        if (f3 == 3'd1 || f3 == 3'd5)
          imm = {1'b0, k == 8, 5'b0, seed[4:0]};
        add_row(itype_word(imm, 5'(1 + k % 4), f3, 5'd5, OPC_IMM));
        add_row(store_to_base(5'd5));
      end
      seed = lcg_next(seed);
      add_row(utype_word(seed[31:12], 5'd5, OPC_LUI));
      add_row(store_to_base(5'd5));
      seed = lcg_next(seed);
      add_row(utype_word(seed[31:12], 5'd6, OPC_AUIPC));
      add_row(store_to_base(5'd6));
      // LB and LBU at offsets 0 to 3, LH and LHU at 0 and 2, then LW
      for (int k = 0; k < 13; k++) begin
        seed = lcg_next(seed);
        w    = seed[21:16];
        if (k < 8) begin
          off = 2'(k / 2);
          f3  = (k % 2 == 0) ? 3'd0 : 3'd4;
        end else if (k < 12) begin
          off = (k % 2 == 0) ? 2'd0 : 2'd2;
          f3  = (k < 10) ? 3'd1 : 3'd5;
        end else begin
          off = 2'd0;
          f3  = 3'd2;
        end
        add_row(itype_word({4'b0, w, off}, 5'd0, f3, 5'd6, OPC_LOAD));
        add_row(store_to_base(5'd6));
      end
      // Each branch condition once taken and once not taken
      for (int k = 0; k < 12; k++) begin
        f3 = (k < 4) ? 3'(k / 2) : 3'(k / 2 + 2);
        if (k < 4) begin
          rs1 = 5'd7;
          rs2 = (k % 2 == 0) ? 5'd7 : 5'd8;
        end else begin
          rs1 = (k % 2 == 0) ? 5'd7 : 5'd8;
          rs2 = (k % 2 == 0) ? 5'd8 : 5'd7;
        end
        add_row(branch_word((k % 2 == 0) ? 13'd12 : -13'd8, rs2, rs1, f3));
      end
      add_row(jal_word(21'd24, 5'd9));
      add_row(store_to_base(5'd9));
      add_row(itype_word(12'd5, 5'd10, 3'd0, 5'd9, OPC_JALR));
      add_row(store_to_base(5'd9));
      add_row(jal_word(-21'd16, 5'd0));
      // Custom-0 opcode, x5 keeps its value
      add_row(32'h0020a28b);
      add_row(store_to_base(5'd5));
      add_row(32'h0);
      add_row(HALT_WORD);
      add_row(store_to_base(5'd1));
      add_row(jal_word(21'd32, 5'd9));
      add_row(store_to_base(5'd9));
      add_row(itype_word(12'd1, 5'd1, 3'd0, 5'd1, OPC_IMM));
    end
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
  endtask

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  initial begin
    logic [31:0] exp_pc;
    pc_errs   = 0;
    mem_errs  = 0;
    flag_errs = 0;
    arst_n    = 1'b1;
    instr     = 32'h0;
    n_rows    = 0;
    spc       = RESET_ADDR;
    shalted   = 1'b0;
    for (int r = 0; r < 32; r++)
      sreg[r] = 32'h0;
    for (int a = 0; a < 64; a++) begin
      mem[a]  = mem_pattern(6'(a));
      smem[a] = mem_pattern(6'(a));
    end
    build_program();
    #10;
    arst_n = 1'b0;
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;
    for (int i = 0; i <= n_rows; i++) begin
      if (i > 0)
        @(negedge CLK);
      exp_pc = (i == 0) ? RESET_ADDR : tab_npc[i-1];
      if (imem_addr !== exp_pc) begin
        pc_errs++;
        show_mismatch("imem_addr_o", imem_addr, exp_pc);
      end
      if (i < n_rows) begin
        instr = tab_insn[i];
        #10;
        if (dmem_wen !== tab_wen[i]) begin
          flag_errs++;
          show_mismatch("dmem_wen_o", dmem_wen, tab_wen[i]);
        end
        if (dmem_ren !== tab_ren[i]) begin
          flag_errs++;
          show_mismatch("dmem_ren_o", dmem_ren, tab_ren[i]);
        end
        if ((tab_wen[i] || tab_ren[i]) && dmem_addr !== tab_addr[i]) begin
          mem_errs++;
          show_mismatch("dmem_addr_o", dmem_addr, tab_addr[i]);
        end
        if (tab_wen[i] && dmem_wdata !== tab_wval[i]) begin
          mem_errs++;
          show_mismatch("dmem_wdata_o", dmem_wdata, tab_wval[i]);
        end
        if (halt !== tab_halt[i]) begin
          flag_errs++;
          show_mismatch("halt_o", halt, tab_halt[i]);
        end
        if (illegal !== tab_ill[i]) begin
          flag_errs++;
          show_mismatch("illegal_o", illegal, tab_ill[i]);
        end
      end
    end
    $display("Error counts: pc %0d, memory %0d, flags %0d", pc_errs, mem_errs, flag_errs);
    if (pc_errs + mem_errs + flag_errs == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  // Table is complete before reset, so its length is known here
  initial begin
    #20;
    #((n_rows + 40) * 100);
    $display("Timeout: run did not finish within %0d cycles", n_rows + 40);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== project.f ====
design/rv32i_pkg.sv
design/control_unit.sv
design/reg_file.sv
design/alu.sv
design/pc_logic.sv
design/writeback_mux.sv
design/rv32i_core.sv
sim/rv32i_core_sva.sv
sim/rv32i_core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = rv32i_core_tb
FILELIST  = project.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
	  echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
